// File: design/cfg_regfile.sv
// Job configuration registers
`timescale 1ns/1ps
`default_nettype none

module cfg_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  tile_pkg::reg_addr_e           wb_adr_i,
  input  logic [tile_pkg::ADDR_W-1:0]   wb_dat_i,
  output logic [tile_pkg::ADDR_W-1:0]   wb_dat_o,
  output logic                          wb_ack_o,
  input  logic                          busy_i,
  input  logic                          done_evt_i,
  output logic                          start_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_addr_o,
  output logic [tile_pkg::ADDR_W-1:0]   w_addr_o,
  output logic [tile_pkg::ADDR_W-1:0]   z_addr_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_iters_o,
  output logic [tile_pkg::ADDR_W-1:0]   w_iters_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_rows_offs_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_d1_stride_o,
  output logic [tile_pkg::ADDR_W-1:0]   w_d0_stride_o,
  output logic [tile_pkg::ADDR_W-1:0]   z_d0_stride_o,
  output logic [tile_pkg::ADDR_W-1:0]   leftovers_o
);
  import tile_pkg::*;

  logic              acc;
  logic              cfg_we;
  logic              done_q;
  logic [ADDR_W-1:0] rdata;

  // The ack cycle is not a new access
  assign acc    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign cfg_we = acc & wb_we_i & ~busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      start_o  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      wb_ack_o <= acc;
      start_o  <= acc & wb_we_i & (wb_adr_i == REG_CTRL) & wb_dat_i[0] & ~busy_i;
      // A new start clears the previous completion
      if (start_o) begin
        done_q <= 1'b0;
      end else if (done_evt_i) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_addr_o      <= '0;
      w_addr_o      <= '0;
      z_addr_o      <= '0;
      x_iters_o     <= '0;
      w_iters_o     <= '0;
      x_rows_offs_o <= '0;
      x_d1_stride_o <= '0;
      w_d0_stride_o <= '0;
      z_d0_stride_o <= '0;
      leftovers_o   <= '0;
    end else if (cfg_we) begin
      case (wb_adr_i)
        REG_X_ADDR:      x_addr_o      <= wb_dat_i;
        REG_W_ADDR:      w_addr_o      <= wb_dat_i;
        REG_Z_ADDR:      z_addr_o      <= wb_dat_i;
        REG_X_ITERS:     x_iters_o     <= wb_dat_i;
        REG_W_ITERS:     w_iters_o     <= wb_dat_i;
        REG_X_ROWS_OFFS: x_rows_offs_o <= wb_dat_i;
        REG_X_D1_STRIDE: x_d1_stride_o <= wb_dat_i;
        REG_W_D0_STRIDE: w_d0_stride_o <= wb_dat_i;
        REG_Z_D0_STRIDE: z_d0_stride_o <= wb_dat_i;
        REG_LEFTOVERS:   leftovers_o   <= wb_dat_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (wb_adr_i)
      REG_STATUS:      rdata = {{(ADDR_W-2){1'b0}}, done_q, busy_i};
      REG_X_ADDR:      rdata = x_addr_o;
      REG_W_ADDR:      rdata = w_addr_o;
      REG_Z_ADDR:      rdata = z_addr_o;
      REG_X_ITERS:     rdata = x_iters_o;
      REG_W_ITERS:     rdata = w_iters_o;
      REG_X_ROWS_OFFS: rdata = x_rows_offs_o;
      REG_X_D1_STRIDE: rdata = x_d1_stride_o;
      REG_W_D0_STRIDE: rdata = w_d0_stride_o;
      REG_Z_D0_STRIDE: rdata = z_d0_stride_o;
      REG_LEFTOVERS:   rdata = leftovers_o;
      // CTRL and unused indices read as zero
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      wb_dat_o <= rdata;
    end
  end

endmodule : cfg_regfile

`default_nettype wire

// File: design/stream_addr_gen.sv
// Strided address generator
`timescale 1ns/1ps
`default_nettype none

module stream_addr_gen #(
  parameter int unsigned LEN_W = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_start_i,
  input  logic [tile_pkg::ADDR_W-1:0]   base_i,
  input  logic [LEN_W-1:0]              d0_len_i,
  input  logic [tile_pkg::ADDR_W-1:0]   d0_stride_i,
  input  logic [LEN_W-1:0]              d1_len_i,
  input  logic [tile_pkg::ADDR_W-1:0]   d1_stride_i,
  output logic                          ready_start_o,
  output logic                          done_o,
  output logic [tile_pkg::ADDR_W-1:0]   addr_o,
  output logic                          valid_o,
  input  logic                          ready_i
);
  import tile_pkg::*;

  logic              busy_q;
  logic              done_q;
  logic              start;
  logic              xfer;
  logic              i0_last;
  logic              i1_last;
  logic [LEN_W-1:0]  i0_q;
  logic [LEN_W-1:0]  i1_q;
  logic [ADDR_W-1:0] d0_offs_q;
  logic [ADDR_W-1:0] d1_offs_q;
  logic [ADDR_W-1:0] base_q;
  logic [LEN_W-1:0]  d0_len_q;
  logic [ADDR_W-1:0] d0_stride_q;
  logic [LEN_W-1:0]  d1_len_q;
  logic [ADDR_W-1:0] d1_stride_q;

  assign start   = req_start_i & ~busy_q;
  assign xfer    = busy_q & ready_i;
  assign i0_last = i0_q == d0_len_q - 1'b1;
  assign i1_last = i1_q == d1_len_q - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      i0_q      <= '0;
      i1_q      <= '0;
      d0_offs_q <= '0;
      d1_offs_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q    <= 1'b1;
        i0_q      <= '0;
        i1_q      <= '0;
        d0_offs_q <= '0;
        d1_offs_q <= '0;
      end else if (xfer) begin
        if (i0_last) begin
          i0_q      <= '0;
          d0_offs_q <= '0;
          if (i1_last) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b1;
            i1_q      <= '0;
            d1_offs_q <= '0;
          end else begin
            i1_q      <= i1_q + 1'b1;
            d1_offs_q <= d1_offs_q + d1_stride_q;
          end
        end else begin
          i0_q      <= i0_q + 1'b1;
          d0_offs_q <= d0_offs_q + d0_stride_q;
        end
      end
    end
  end

  // Job parameters held for the whole job
  always_ff @(posedge clk_i) begin
    if (start) begin
      base_q      <= base_i;
      d0_len_q    <= d0_len_i;
      d0_stride_q <= d0_stride_i;
      d1_len_q    <= d1_len_i;
      d1_stride_q <= d1_stride_i;
    end
  end

  assign ready_start_o = ~busy_q;
  assign done_o        = done_q;
  assign valid_o       = busy_q;
  assign addr_o        = base_q + d1_offs_q + d0_offs_q;

endmodule : stream_addr_gen

`default_nettype wire

// File: design/tile_ctrl.sv
// Job controller
`timescale 1ns/1ps
`default_nettype none

module tile_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic all_done_i,
  output logic first_load_o,
  output logic busy_o,
  output logic done_evt_o,
  output logic irq_o
);
  import tile_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CS_IDLE: begin
        if (start_i) begin
          state_d = CS_LOAD;
        end
      end
      // Single cycle that kicks off W, Z and the first X job
      CS_LOAD: begin
        state_d = CS_RUN;
      end
      CS_RUN: begin
        if (all_done_i) begin
          state_d = CS_DONE;
        end
      end
      CS_DONE: begin
        // Host may already restart while done is being reported
        if (start_i) begin
          state_d = CS_LOAD;
        end else begin
          state_d = CS_IDLE;
        end
      end
      default: begin
        state_d = CS_IDLE;
      end
    endcase
  end

  assign first_load_o = state_q == CS_LOAD;
  assign busy_o       = (state_q == CS_LOAD) || (state_q == CS_RUN);
  assign done_evt_o   = state_q == CS_DONE;
  assign irq_o        = state_q == CS_DONE;

endmodule : tile_ctrl

`default_nettype wire

// File: design/tile_pkg.sv
// Tiling front end shared definitions
`default_nettype none

package tile_pkg;

  // Address and register width
  localparam int unsigned ADDR_W = 32;

  // Iteration counter width, half a register word
  localparam int unsigned CNT_W = 16;

  localparam int unsigned NUM_REGS = 12;

  // Word index of each register on the configuration bus
  typedef enum logic [3:0] {
    REG_CTRL        = 4'd0,
    REG_STATUS      = 4'd1,
    REG_X_ADDR      = 4'd2,
    REG_W_ADDR      = 4'd3,
    REG_Z_ADDR      = 4'd4,
    REG_X_ITERS     = 4'd5,
    REG_W_ITERS     = 4'd6,
    REG_X_ROWS_OFFS = 4'd7,
    REG_X_D1_STRIDE = 4'd8,
    REG_W_D0_STRIDE = 4'd9,
    REG_Z_D0_STRIDE = 4'd10,
    REG_LEFTOVERS   = 4'd11
  } reg_addr_e;

  // Job controller states
  typedef enum logic [1:0] {
    CS_IDLE = 2'd0,
    CS_LOAD = 2'd1,
    CS_RUN  = 2'd2,
    CS_DONE = 2'd3
  } ctrl_state_e;

endpackage : tile_pkg

`default_nettype wire

// File: design/tile_scheduler.sv
// Tiling scheduler
`timescale 1ns/1ps
`default_nettype none

module tile_scheduler #(
  parameter int unsigned  ARRAY_W  = 4,
  parameter int unsigned  TILE_JMP = 16,
  localparam int unsigned LEN_W    = $clog2(ARRAY_W) + 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          first_load_i,
  input  logic [tile_pkg::ADDR_W-1:0]   x_addr_i,
  input  logic [tile_pkg::ADDR_W-1:0]   x_iters_i,
  input  logic [tile_pkg::ADDR_W-1:0]   w_iters_i,
  input  logic [tile_pkg::ADDR_W-1:0]   x_rows_offs_i,
  input  logic [tile_pkg::ADDR_W-1:0]   leftovers_i,
  input  logic                          x_done_i,
  input  logic                          w_done_i,
  input  logic                          z_done_i,
  input  logic                          x_ready_start_i,
  input  logic                          w_ready_start_i,
  input  logic                          z_ready_start_i,
  output logic                          x_req_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_base_o,
  output logic [LEN_W-1:0]              x_len_o,
  output logic                          w_req_o,
  output logic                          z_req_o,
  output logic                          all_done_o
);
  import tile_pkg::*;

  logic [CNT_W-1:0]  col_q;
  logic [CNT_W-1:0]  wt_q;
  logic [CNT_W-1:0]  row_q;
  logic [ADDR_W-1:0] col_offs_q;
  logic [ADDR_W-1:0] row_offs_q;
  logic              col_last;
  logic              wt_last;
  logic              row_last;
  logic              job_last;
  logic              x_pend_q;
  logic              x_fin_q;
  logic              w_fin_q;
  logic              z_fin_q;

  assign col_last = col_q == x_iters_i[CNT_W-1:0] - 1'b1;
  assign wt_last  = wt_q == w_iters_i[CNT_W-1:0] - 1'b1;
  assign row_last = row_q == x_iters_i[2*CNT_W-1:CNT_W] - 1'b1;
  assign job_last = col_last & wt_last & row_last;

  // Column innermost, then weight tile, then row tile
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q      <= '0;
      wt_q       <= '0;
      row_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (start_i) begin
      col_q      <= '0;
      wt_q       <= '0;
      row_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (x_done_i) begin
      col_q      <= col_last ? '0 : col_q + 1'b1;
      col_offs_q <= col_last ? '0 : col_offs_q + ADDR_W'(TILE_JMP);
      if (col_last) begin
        wt_q <= wt_last ? '0 : wt_q + 1'b1;
        if (wt_last) begin
          row_q      <= row_last ? '0 : row_q + 1'b1;
          row_offs_q <= row_last ? '0 : row_offs_q + x_rows_offs_i;
        end
      end
    end
  end

  // Completion tracking, the next X job waits here for a free generator
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_pend_q <= 1'b0;
      x_fin_q  <= 1'b0;
      w_fin_q  <= 1'b0;
      z_fin_q  <= 1'b0;
    end else if (start_i) begin
      x_pend_q <= 1'b0;
      x_fin_q  <= 1'b0;
      w_fin_q  <= 1'b0;
      z_fin_q  <= 1'b0;
    end else begin
      if (x_done_i && !job_last) begin
        x_pend_q <= 1'b1;
      end else if (x_req_o) begin
        x_pend_q <= 1'b0;
      end
      if (x_done_i && job_last) begin
        x_fin_q <= 1'b1;
      end
      if (w_done_i) begin
        w_fin_q <= 1'b1;
      end
      if (z_done_i) begin
        z_fin_q <= 1'b1;
      end
    end
  end

  assign x_base_o = x_addr_i + row_offs_q + col_offs_q;

  // Last row tile may be short
  assign x_len_o = (row_last && leftovers_i != '0) ? leftovers_i[LEN_W-1:0]
                                                   : LEN_W'(ARRAY_W);

  assign x_req_o = (first_load_i || x_pend_q) && x_ready_start_i;
  assign w_req_o = first_load_i && w_ready_start_i;
  assign z_req_o = first_load_i && z_ready_start_i;

  assign all_done_o = x_fin_q & w_fin_q & z_fin_q;

endmodule : tile_scheduler

`default_nettype wire

// File: design/tile_stream_top.sv
// Tiling front end top level
`timescale 1ns/1ps
`default_nettype none

module tile_stream_top #(
  parameter int unsigned ARRAY_W  = 4,
  parameter int unsigned TILE_JMP = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  tile_pkg::reg_addr_e           wb_adr_i,
  input  logic [tile_pkg::ADDR_W-1:0]   wb_dat_i,
  output logic [tile_pkg::ADDR_W-1:0]   wb_dat_o,
  output logic                          wb_ack_o,
  output logic [tile_pkg::ADDR_W-1:0]   x_addr_o,
  output logic                          x_valid_o,
  input  logic                          x_ready_i,
  output logic [tile_pkg::ADDR_W-1:0]   w_addr_o,
  output logic                          w_valid_o,
  input  logic                          w_ready_i,
  output logic [tile_pkg::ADDR_W-1:0]   z_addr_o,
  output logic                          z_valid_o,
  input  logic                          z_ready_i,
  output logic                          irq_o
);
  import tile_pkg::*;

  localparam int unsigned X_LEN_W = $clog2(ARRAY_W) + 1;

  logic              start, busy, done_evt, first_load, all_done;
  logic [ADDR_W-1:0] x_addr, w_addr, z_addr, x_iters, w_iters;
  logic [ADDR_W-1:0] x_rows_offs, x_d1_stride, w_d0_stride, z_d0_stride, leftovers;
  logic              x_req, w_req, z_req, x_done, w_done, z_done;
  logic              x_ready_start, w_ready_start, z_ready_start;
  logic [ADDR_W-1:0] x_base;
  logic [X_LEN_W-1:0] x_len;

  cfg_regfile cfg_regfile_i (
    .clk_i, .rst_ni, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .busy_i(busy), .done_evt_i(done_evt), .start_o(start),
    .x_addr_o(x_addr), .w_addr_o(w_addr), .z_addr_o(z_addr),
    .x_iters_o(x_iters), .w_iters_o(w_iters), .x_rows_offs_o(x_rows_offs),
    .x_d1_stride_o(x_d1_stride), .w_d0_stride_o(w_d0_stride),
    .z_d0_stride_o(z_d0_stride), .leftovers_o(leftovers)
  );

  tile_ctrl tile_ctrl_i (
    .clk_i, .rst_ni, .start_i(start), .all_done_i(all_done),
    .first_load_o(first_load), .busy_o(busy), .done_evt_o(done_evt), .irq_o
  );

  tile_scheduler #(.ARRAY_W(ARRAY_W), .TILE_JMP(TILE_JMP)) tile_scheduler_i (
    .clk_i, .rst_ni, .start_i(start), .first_load_i(first_load),
    .x_addr_i(x_addr), .x_iters_i(x_iters), .w_iters_i(w_iters),
    .x_rows_offs_i(x_rows_offs), .leftovers_i(leftovers),
    .x_done_i(x_done), .w_done_i(w_done), .z_done_i(z_done),
    .x_ready_start_i(x_ready_start), .w_ready_start_i(w_ready_start),
    .z_ready_start_i(z_ready_start), .x_req_o(x_req), .x_base_o(x_base),
    .x_len_o(x_len), .w_req_o(w_req), .z_req_o(z_req), .all_done_o(all_done)
  );

  // X walks one tile column, one address per row
  stream_addr_gen #(.LEN_W(X_LEN_W)) x_gen_i (
    .clk_i, .rst_ni, .req_start_i(x_req), .base_i(x_base),
    .d0_len_i(X_LEN_W'(1)), .d0_stride_i('0), .d1_len_i(x_len), .d1_stride_i(x_d1_stride),
    .ready_start_o(x_ready_start), .done_o(x_done),
    .addr_o(x_addr_o), .valid_o(x_valid_o), .ready_i(x_ready_i)
  );

  stream_addr_gen #(.LEN_W(CNT_W)) w_gen_i (
    .clk_i, .rst_ni, .req_start_i(w_req), .base_i(w_addr),
    .d0_len_i(w_iters[2*CNT_W-1:CNT_W]), .d0_stride_i(w_d0_stride),
    .d1_len_i(w_iters[CNT_W-1:0]), .d1_stride_i(ADDR_W'(TILE_JMP)),
    .ready_start_o(w_ready_start), .done_o(w_done),
    .addr_o(w_addr_o), .valid_o(w_valid_o), .ready_i(w_ready_i)
  );

  stream_addr_gen #(.LEN_W(CNT_W)) z_gen_i (
    .clk_i, .rst_ni, .req_start_i(z_req), .base_i(z_addr),
    .d0_len_i(CNT_W'(ARRAY_W)), .d0_stride_i(z_d0_stride),
    .d1_len_i(w_iters[CNT_W-1:0]), .d1_stride_i(ADDR_W'(TILE_JMP)),
    .ready_start_o(z_ready_start), .done_o(z_done),
    .addr_o(z_addr_o), .valid_o(z_valid_o), .ready_i(z_ready_i)
  );

endmodule : tile_stream_top

`default_nettype wire

// File: dv/tb_tile_stream.sv
// Tiling front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tile_stream;
  import tile_pkg::*;

  localparam int unsigned ARRAY_W     = 4;
  localparam int unsigned TILE_JMP    = 16;
  localparam int unsigned WB_TIMEOUT  = 100;
  localparam int unsigned JOB_TIMEOUT = 20000;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  reg_addr_e         wb_adr;
  logic [ADDR_W-1:0] wb_wdata;
  logic [ADDR_W-1:0] wb_rdata;
  logic              wb_ack;
  logic [ADDR_W-1:0] x_addr;
  logic [ADDR_W-1:0] w_addr;
  logic [ADDR_W-1:0] z_addr;
  logic              x_valid;
  logic              w_valid;
  logic              z_valid;
  logic              x_ready;
  logic              w_ready;
  logic              z_ready;
  logic              irq;

  logic [ADDR_W-1:0] got_x[$];
  logic [ADDR_W-1:0] got_w[$];
  logic [ADDR_W-1:0] got_z[$];
  logic [ADDR_W-1:0] exp_x[$];
  logic [ADDR_W-1:0] exp_w[$];
  logic [ADDR_W-1:0] exp_z[$];

  int unsigned mismatches;
  int unsigned failures;
  int unsigned irq_count;
  int unsigned watchdog_cycles;
  logic        bp_mode;
  logic [31:0] lcg_state;

  // Job geometry as programmed into the registers
  logic [ADDR_W-1:0] cfg_x_addr;
  logic [ADDR_W-1:0] cfg_w_addr;
  logic [ADDR_W-1:0] cfg_z_addr;
  logic [CNT_W-1:0]  cfg_cols;
  logic [CNT_W-1:0]  cfg_rows;
  logic [CNT_W-1:0]  cfg_wts;
  logic [CNT_W-1:0]  cfg_wrows;
  logic [ADDR_W-1:0] cfg_rows_offs;
  logic [ADDR_W-1:0] cfg_x_d1;
  logic [ADDR_W-1:0] cfg_w_d0;
  logic [ADDR_W-1:0] cfg_z_d0;
  logic [ADDR_W-1:0] cfg_left;

  tile_stream_top tile_stream_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdata),
    .wb_dat_o  (wb_rdata),
    .wb_ack_o  (wb_ack),
    .x_addr_o  (x_addr),
    .x_valid_o (x_valid),
    .x_ready_i (x_ready),
    .w_addr_o  (w_addr),
    .w_valid_o (w_valid),
    .w_ready_i (w_ready),
    .z_addr_o  (z_addr),
    .z_valid_o (z_valid),
    .z_ready_i (z_ready),
    .irq_o     (irq)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Sink ready is steady or pseudo-random
  always @(posedge clk_i) begin
    if (bp_mode) begin
      lcg_state = lcg_next(lcg_state);
      x_ready <= lcg_state[16];
      w_ready <= lcg_state[21];
      z_ready <= lcg_state[27];
    end else begin
      x_ready <= 1'b1;
      w_ready <= 1'b1;
      z_ready <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (x_valid && x_ready) got_x.push_back(x_addr);
    if (w_valid && w_ready) got_w.push_back(w_addr);
    if (z_valid && z_ready) got_z.push_back(z_addr);
    if (irq) irq_count++;
  end

  task automatic check_word(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input int idx, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("FAILED %s[%0d]: expected %08h, actual %08h", name, idx, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatches++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [ADDR_W-1:0] data);
    int unsigned n;
    @(posedge clk_i);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_wdata <= data;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (wb_ack !== 1'b1 && n < WB_TIMEOUT);
    if (wb_ack !== 1'b1) begin
      failures++;
      $display("Write to register %0d got no Wishbone acknowledge", adr);
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input reg_addr_e adr, output logic [ADDR_W-1:0] data);
    int unsigned n;
    @(posedge clk_i);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (wb_ack !== 1'b1 && n < WB_TIMEOUT);
    if (wb_ack !== 1'b1) begin
      failures++;
      $display("Read of register %0d got no Wishbone acknowledge", adr);
    end
    data = wb_rdata;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // Expected address lists with the column tile innermost and the row tile outermost
  task automatic build_model();
    int r;
    int w;
    int c;
    int k;
    int len;
    logic [ADDR_W-1:0] base;
    exp_x.delete();
    exp_w.delete();
    exp_z.delete();
    for (r = 0; r < cfg_rows; r++) begin
      for (w = 0; w < cfg_wts; w++) begin
        for (c = 0; c < cfg_cols; c++) begin
          base = cfg_x_addr + r * cfg_rows_offs + c * TILE_JMP;
          len = (r == cfg_rows - 1 && cfg_left != 0) ? cfg_left : ARRAY_W;
          for (k = 0; k < len; k++) exp_x.push_back(base + k * cfg_x_d1);
        end
      end
    end
    for (w = 0; w < cfg_wts; w++) begin
      for (k = 0; k < cfg_wrows; k++) exp_w.push_back(cfg_w_addr + w * TILE_JMP + k * cfg_w_d0);
      for (k = 0; k < ARRAY_W; k++) exp_z.push_back(cfg_z_addr + w * TILE_JMP + k * cfg_z_d0);
    end
  endtask

  function automatic int unsigned job_addrs(input int unsigned cols, input int unsigned rows,
                                            input int unsigned wts, input int unsigned wrows,
                                            input int unsigned left);
    int unsigned last_len;
    last_len = (left != 0) ? left : ARRAY_W;
    return cols * wts * ((rows - 1) * ARRAY_W + last_len) + wts * (wrows + ARRAY_W);
  endfunction

  task automatic compare_streams(input string name);
    int i;
    check_count({name, " x count"}, exp_x.size(), got_x.size());
    check_count({name, " w count"}, exp_w.size(), got_w.size());
    check_count({name, " z count"}, exp_z.size(), got_z.size());
    for (i = 0; i < exp_x.size() && i < got_x.size(); i++)
      check_addr({name, " x"}, i, exp_x[i], got_x[i]);
    for (i = 0; i < exp_w.size() && i < got_w.size(); i++)
      check_addr({name, " w"}, i, exp_w[i], got_w[i]);
    for (i = 0; i < exp_z.size() && i < got_z.size(); i++)
      check_addr({name, " z"}, i, exp_z[i], got_z[i]);
  endtask

  task automatic set_multi_config();
    cfg_x_addr    = 32'h0001_0000;
    cfg_w_addr    = 32'h0002_0000;
    cfg_z_addr    = 32'h0003_0000;
    cfg_cols      = 16'd2;
    cfg_rows      = 16'd3;
    cfg_wts       = 16'd3;
    cfg_wrows     = 16'd2;
    cfg_rows_offs = 32'h100;
    cfg_x_d1      = 32'h40;
    cfg_w_d0      = 32'h20;
    cfg_z_d0      = 32'h80;
    cfg_left      = 32'h0;
  endtask

  task automatic write_config();
    wb_write(REG_X_ADDR, cfg_x_addr);
    wb_write(REG_W_ADDR, cfg_w_addr);
    wb_write(REG_Z_ADDR, cfg_z_addr);
    wb_write(REG_X_ITERS, {cfg_rows, cfg_cols});
    wb_write(REG_W_ITERS, {cfg_wrows, cfg_wts});
    wb_write(REG_X_ROWS_OFFS, cfg_rows_offs);
    wb_write(REG_X_D1_STRIDE, cfg_x_d1);
    wb_write(REG_W_D0_STRIDE, cfg_w_d0);
    wb_write(REG_Z_D0_STRIDE, cfg_z_d0);
    wb_write(REG_LEFTOVERS, cfg_left);
  endtask

  task automatic start_job();
    got_x.delete();
    got_w.delete();
    got_z.delete();
    irq_count = 0;
    build_model();
    wb_write(REG_CTRL, 32'h1);
  endtask

  task automatic finish_job(input string name);
    int unsigned n;
    logic [ADDR_W-1:0] status;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (irq !== 1'b1 && n < JOB_TIMEOUT);
    if (irq !== 1'b1) begin
      failures++;
      $display("Timed out waiting for the completion interrupt in %s", name);
    end
    wb_read(REG_STATUS, status);
    check_word({name, " status"}, 32'h2, status);
    check_count({name, " irq pulses"}, 1, irq_count);
    compare_streams(name);
  endtask

  task automatic test_registers();
    int i;
    logic [ADDR_W-1:0] data;
    wb_read(REG_STATUS, data);
    check_word("reset status", 32'h0, data);
    for (i = 2; i < NUM_REGS; i++) wb_write(reg_addr_e'(i), 32'h9E37_0000 + i * 32'h0011_0203);
    for (i = 2; i < NUM_REGS; i++) begin
      wb_read(reg_addr_e'(i), data);
      check_word($sformatf("register %0d", i), 32'h9E37_0000 + i * 32'h0011_0203, data);
    end
  endtask

  task automatic test_single_tile();
    set_multi_config();
    cfg_cols  = 16'd1;
    cfg_rows  = 16'd1;
    cfg_wts   = 16'd1;
    cfg_wrows = 16'd3;
    write_config();
    start_job();
    finish_job("single tile");
  endtask

  task automatic test_multi_tile();
    set_multi_config();
    write_config();
    start_job();
    finish_job("multi tile");
  endtask

  task automatic test_leftovers();
    set_multi_config();
    cfg_left = 32'd3;
    write_config();
    start_job();
    finish_job("leftovers");
  endtask

  task automatic test_backpressure();
    set_multi_config();
    write_config();
    bp_mode = 1'b1;
    start_job();
    finish_job("back-pressure");
    bp_mode = 1'b0;
  endtask

  task automatic test_busy_restart();
    logic [ADDR_W-1:0] data;
    set_multi_config();
    write_config();
    start_job();
    // Both writes land while the job runs and must be dropped
    wb_write(REG_X_ADDR, 32'hDEAD_0000);
    wb_write(REG_X_D1_STRIDE, 32'h44);
    finish_job("busy write");
    wb_read(REG_X_ADDR, data);
    check_word("busy write x_addr", cfg_x_addr, data);
    start_job();
    wb_read(REG_STATUS, data);
    check_word("restart status", 32'h1, data);
    finish_job("restart");
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_ni     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = REG_CTRL;
    wb_wdata   = '0;
    x_ready    = 1'b1;
    w_ready    = 1'b1;
    z_ready    = 1'b1;
    bp_mode    = 1'b0;
    lcg_state  = 32'h34148a64;
    mismatches = 0;
    failures   = 0;
    irq_count  = 0;
    // The multi-tile geometry runs in four jobs
    watchdog_cycles = 200 * (job_addrs(1, 1, 1, 3, 0) + 4 * job_addrs(2, 3, 3, 2, 0)
                             + job_addrs(2, 3, 3, 2, 3)) + 2000;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_registers();
    test_single_tile();
    test_multi_tile();
    test_leftovers();
    test_backpressure();
    test_busy_restart();
    @(posedge clk_i);
    $display("Run complete: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_tile_stream

`default_nettype wire

// File: vlog.f
design/tile_pkg.sv
design/cfg_regfile.sv
design/tile_ctrl.sv
design/tile_scheduler.sv
design/stream_addr_gen.sv
design/tile_stream_top.sv
dv/tb_tile_stream.sv
